// ==== Makefile ====
TB = tb_blake512

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sources.f --top-module blake512_core
	verilator --lint-only --timing -f sources.f --top-module $(TB)

sim:
	verilator --binary --timing -f sources.f --top-module $(TB) -o $(TB)
	@out="$$(./obj_dir/$(TB))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -x "=== PASS ==="

clean:
	rm -rf obj_dir

// ==== blake512_core.sv ====
// top level of the BLAKE-512 pipeline: one header in and one digest out per clock

`timescale 1ns/1ps
`default_nettype none

module blake512_core
	import blake_types_pkg::*;
(
	input  wire          clk,
	input  wire          rst,
	input  wire header_t data,
	input  wire half_t   nonce,
	output wire digest_t hash,
	output wire          hash_valid
);

	// entry r feeds round r, the last one feeds finalize
	wire block_t blk [NUM_ROUNDS+1];
	wire state_t st  [NUM_ROUNDS+1];

	blake_init u_init (
		.clk   (clk),
		.data  (data),
		.nonce (nonce),
		.blk   (blk[0]),
		.st    (st[0])
	);

	for (genvar r = 0; r < NUM_ROUNDS; r++) begin : g_round
		blake_round #(
			.ROUND (r)
		) u_round (
			.clk     (clk),
			.st_in   (st[r]),
			.blk_in  (blk[r]),
			.st_out  (st[r+1]),
			.blk_out (blk[r+1])
		);
	end

	// message block leaving the last round is not needed
	blake_finalize u_finalize (
		.clk        (clk),
		.rst        (rst),
		.st         (st[NUM_ROUNDS]),
		.hash       (hash),
		.hash_valid (hash_valid)
	);

endmodule

`default_nettype wire

// ==== blake_const_pkg.sv ====
// BLAKE-512 constant tables: IV, pi constants, sigma, rotations and padding

package blake_const_pkg;

	import blake_types_pkg::*;

	// chain value, same as the SHA-512 IV
	localparam word_t BLAKE_IV [8] = '{
		64'h6A09E667F3BCC908, 64'hBB67AE8584CAA73B,
		64'h3C6EF372FE94F82B, 64'hA54FF53A5F1D36F1,
		64'h510E527FADE682D1, 64'h9B05688C2B3E6C1F,
		64'h1F83D9ABFB41BD6B, 64'h5BE0CD19137E2179
	};

	// leading digits of pi
	localparam word_t BLAKE_C [16] = '{
		64'h243F6A8885A308D3, 64'h13198A2E03707344,
		64'hA4093822299F31D0, 64'h082EFA98EC4E6C89,
		64'h452821E638D01377, 64'hBE5466CF34E90C6C,
		64'hC0AC29B7C97C50DD, 64'h3F84D5B5B5470917,
		64'h9216D5D98979FB1B, 64'hD1310BA698DFB5AC,
		64'h2FFD72DBD01ADFB7, 64'hB8E1AFED6A267E96,
		64'hBA7C9045F12C7F99, 64'h24A19947B3916CF7,
		64'h0801F2E2858EFC16, 64'h636920D871574E69
	};

	// message permutation, round r uses row r mod 10
	localparam logic [3:0] SIGMA [10][16] = '{
		'{ 0,  1,  2,  3,  4,  5,  6,  7,  8,  9, 10, 11, 12, 13, 14, 15},
		'{14, 10,  4,  8,  9, 15, 13,  6,  1, 12,  0,  2, 11,  7,  5,  3},
		'{11,  8, 12,  0,  5,  2, 15, 13, 10, 14,  3,  6,  7,  1,  9,  4},
		'{ 7,  9,  3,  1, 13, 12, 11, 14,  2,  6,  5, 10,  4,  0, 15,  8},
		'{ 9,  0,  5,  7,  2,  4, 10, 15, 14,  1, 11, 12,  6,  8,  3, 13},
		'{ 2, 12,  6, 10,  0, 11,  8,  3,  4, 13,  7,  5, 15, 14,  1,  9},
		'{12,  5,  1, 15, 14, 13,  4, 10,  0,  7,  6,  3,  9,  2,  8, 11},
		'{13, 11,  7, 14, 12,  1,  3,  9,  5,  0, 15,  4,  8,  6,  2, 10},
		'{ 6, 15, 14,  9, 11,  3,  0,  8, 12,  2, 13,  7,  1,  4, 10,  5},
		'{10,  2,  8,  4,  7,  6,  1,  5, 15, 11,  9, 14,  3, 12, 13,  0}
	};

	// right-rotate amounts of G
	localparam int ROT_R1 = 32;
	localparam int ROT_R2 = 25;
	localparam int ROT_R3 = 16;
	localparam int ROT_R4 = 11;

	// 80-byte header is 640 bits
	localparam word_t MSG_BITS = 64'd640;

	// words 10..15: pad bit, zeros, final-block marker, 128-bit length
	localparam logic [383:0] PAD_TAIL = {
		64'h8000000000000000,
		64'h0000000000000000,
		64'h0000000000000000,
		64'h0000000000000001,
		64'h0000000000000000,
		MSG_BITS
	};

endpackage

// ==== blake_finalize.sv ====
// feed-forward digest register and fill counter behind hash_valid at the end of the pipeline

`timescale 1ns/1ps
`default_nettype none

module blake_finalize
	import blake_types_pkg::*;
	import blake_const_pkg::*;
(
	input  wire         clk,
	input  wire         rst,
	input  wire state_t st,
	output digest_t     hash,
	output logic        hash_valid
);

	fill_t fill_cnt;

	// h_i = iv_i ^ v_i ^ v_(i+8) of a single unsalted block
	always_ff @(posedge clk) begin
		for (int i = 0; i < 8; i++) begin
			hash[DIGEST_W-1-WORD_W*i -: WORD_W] <=
				BLAKE_IV[i] ^ get_word(st, i) ^ get_word(st, i + 8);
		end
	end

	// counts edges since reset and stops once the pipe is full
	always_ff @(posedge clk) begin
		if (rst) begin
			fill_cnt <= '0;
		end else if (fill_cnt != fill_t'(PIPE_LATENCY)) begin
			fill_cnt <= fill_cnt + fill_t'(1);
		end
	end

	assign hash_valid = (fill_cnt == fill_t'(PIPE_LATENCY));

endmodule

`default_nettype wire

// ==== blake_g.sv ====
// one BLAKE-512 G function as two registered half-steps, used eight times per round

`timescale 1ns/1ps
`default_nettype none

module blake_g
	import blake_types_pkg::*;
	import blake_const_pkg::*;
(
	input  wire        clk,
	input  wire word_t a,
	input  wire word_t b,
	input  wire word_t c,
	input  wire word_t d,
	// m0 is used at the input edge, m1 one clock later
	input  wire word_t m0,
	input  wire word_t m1,
	output word_t      a_out,
	output word_t      b_out,
	output word_t      c_out,
	output word_t      d_out
);

	word_t a0_d, b0_d, c0_d, d0_d;
	word_t a0_q, b0_q, c0_q, d0_q;
	word_t a1_d, b1_d, c1_d, d1_d;

	function automatic word_t ror(input word_t x, input int n);
		return (x >> n) | (x << (WORD_W - n));
	endfunction

	// first half-step
	always_comb begin
		a0_d = a + b + m0;
		d0_d = ror(d ^ a0_d, ROT_R1);
		c0_d = c + d0_d;
		b0_d = ror(b ^ c0_d, ROT_R2);
	end

	always_ff @(posedge clk) begin
		a0_q <= a0_d;
		b0_q <= b0_d;
		c0_q <= c0_d;
		d0_q <= d0_d;
	end

	// second half-step on the registered words
	always_comb begin
		a1_d = a0_q + b0_q + m1;
		d1_d = ror(d0_q ^ a1_d, ROT_R3);
		c1_d = c0_q + d1_d;
		b1_d = ror(b0_q ^ c1_d, ROT_R4);
	end

	always_ff @(posedge clk) begin
		a_out <= a1_d;
		b_out <= b1_d;
		c_out <= c1_d;
		d_out <= d1_d;
	end

endmodule

`default_nettype wire

// ==== blake_init.sv ====
// input stage of the BLAKE-512 pipeline: pads the header and builds the initial state

`timescale 1ns/1ps
`default_nettype none

module blake_init
	import blake_types_pkg::*;
	import blake_const_pkg::*;
(
	input  wire          clk,
	input  wire header_t data,
	input  wire half_t   nonce,
	output block_t       blk,
	output state_t       st
);

	always_ff @(posedge clk) begin
		// header, nonce in the low half of word 9, then padding
		blk <= {data, nonce, PAD_TAIL};

		// constant, but registered so it lines up with the block
		st <= {
			BLAKE_IV[0], BLAKE_IV[1], BLAKE_IV[2], BLAKE_IV[3],
			BLAKE_IV[4], BLAKE_IV[5], BLAKE_IV[6], BLAKE_IV[7],
			BLAKE_C[0], BLAKE_C[1], BLAKE_C[2], BLAKE_C[3],
			// counter goes into v12 and v13
			BLAKE_C[4] ^ MSG_BITS,
			BLAKE_C[5] ^ MSG_BITS,
			BLAKE_C[6], BLAKE_C[7]
		};
	end

endmodule

`default_nettype wire

// ==== blake_round.sv ====
// one four-clock BLAKE-512 round with its block delay line for the core to chain sixteen times

`timescale 1ns/1ps
`default_nettype none

module blake_round
	import blake_types_pkg::*;
	import blake_const_pkg::*;
#(
	parameter int ROUND = 0
) (
	input  wire         clk,
	input  wire state_t st_in,
	input  wire block_t blk_in,
	output wire state_t st_out,
	output block_t      blk_out
);

	// blk_d[k] is blk_in delayed by k+1 clocks
	block_t blk_d [4];
	wire state_t st_mid;

	word_t m_col0 [4];
	word_t m_col1 [4];
	word_t m_dia0 [4];
	word_t m_dia1 [4];

	always_ff @(posedge clk) begin
		blk_d[0] <= blk_in;
		for (int k = 1; k < 4; k++) begin
			blk_d[k] <= blk_d[k-1];
		end
	end

	assign blk_out = blk_d[3];

	// each message word is taken from the block copy that matches
	// the clock its half-step runs in
	always_comb begin
		for (int k = 0; k < 4; k++) begin
			m_col0[k] = get_word(blk_in, int'(SIGMA[ROUND % 10][2*k]))
				^ BLAKE_C[SIGMA[ROUND % 10][2*k+1]];
			m_col1[k] = get_word(blk_d[0], int'(SIGMA[ROUND % 10][2*k+1]))
				^ BLAKE_C[SIGMA[ROUND % 10][2*k]];
			m_dia0[k] = get_word(blk_d[1], int'(SIGMA[ROUND % 10][2*k+8]))
				^ BLAKE_C[SIGMA[ROUND % 10][2*k+9]];
			m_dia1[k] = get_word(blk_d[2], int'(SIGMA[ROUND % 10][2*k+9]))
				^ BLAKE_C[SIGMA[ROUND % 10][2*k+8]];
		end
	end

	// column G on words i, i+4, i+8 and i+12
	for (genvar i = 0; i < 4; i++) begin : g_col
		blake_g u_g (
			.clk   (clk),
			.a     (get_word(st_in, i)),
			.b     (get_word(st_in, i + 4)),
			.c     (get_word(st_in, i + 8)),
			.d     (get_word(st_in, i + 12)),
			.m0    (m_col0[i]),
			.m1    (m_col1[i]),
			.a_out (st_mid[STATE_W-1-WORD_W*i -: WORD_W]),
			.b_out (st_mid[STATE_W-1-WORD_W*(i+4) -: WORD_W]),
			.c_out (st_mid[STATE_W-1-WORD_W*(i+8) -: WORD_W]),
			.d_out (st_mid[STATE_W-1-WORD_W*(i+12) -: WORD_W])
		);
	end

	// diagonal G on words 0,5,10,15 / 1,6,11,12 / 2,7,8,13 / 3,4,9,14
	for (genvar i = 0; i < 4; i++) begin : g_dia
		blake_g u_g (
			.clk   (clk),
			.a     (get_word(st_mid, i)),
			.b     (get_word(st_mid, 4 + (i + 1) % 4)),
			.c     (get_word(st_mid, 8 + (i + 2) % 4)),
			.d     (get_word(st_mid, 12 + (i + 3) % 4)),
			.m0    (m_dia0[i]),
			.m1    (m_dia1[i]),
			.a_out (st_out[STATE_W-1-WORD_W*i -: WORD_W]),
			.b_out (st_out[STATE_W-1-WORD_W*(4 + (i + 1) % 4) -: WORD_W]),
			.c_out (st_out[STATE_W-1-WORD_W*(8 + (i + 2) % 4) -: WORD_W]),
			.d_out (st_out[STATE_W-1-WORD_W*(12 + (i + 3) % 4) -: WORD_W])
		);
	end

endmodule

`default_nettype wire

// ==== blake_types_pkg.sv ====
// widths, vector types and pipeline timing shared by every BLAKE-512 design file

package blake_types_pkg;

	localparam int WORD_W   = 64;
	localparam int HALF_W   = 32;
	localparam int HEADER_W = 608;
	localparam int BLOCK_W  = 1024;
	localparam int STATE_W  = 1024;
	localparam int DIGEST_W = 512;

	// one BLAKE-512 word
	typedef logic [WORD_W-1:0]   word_t;
	// nonce width
	typedef logic [HALF_W-1:0]   half_t;
	// header data field, without the nonce
	typedef logic [HEADER_W-1:0] header_t;
	// sixteen message words, word 0 in the top bits
	typedef logic [BLOCK_W-1:0]  block_t;
	// working state v0..v15, v0 in the top bits
	typedef logic [STATE_W-1:0]  state_t;
	// h0 in the top bits
	typedef logic [DIGEST_W-1:0] digest_t;

	localparam int NUM_ROUNDS   = 16;
	localparam int ROUND_CYCLES = 4;

	// init register, then the rounds; the digest register closes the count
	localparam int PIPE_LATENCY = 1 + NUM_ROUNDS * ROUND_CYCLES + 0;

	// fill counter must reach PIPE_LATENCY
	localparam int FILL_W = $clog2(PIPE_LATENCY + 1);

	typedef logic [FILL_W-1:0] fill_t;

	// word idx of a 1024-bit vector, word 0 at the top
	// blocks have the same layout, so this serves both
	function automatic word_t get_word(input state_t v, input int idx);
		return v[STATE_W-1-WORD_W*idx -: WORD_W];
	endfunction

endpackage

// ==== sources.f ====
+incdir+.
blake_types_pkg.sv
blake_const_pkg.sv
blake_g.sv
blake_round.sv
blake_init.sv
blake_finalize.sv
blake512_core.sv
tb_blake512.sv

// ==== blake512_model.svh ====
// reference BLAKE-512 model of one padded header, included by the testbench after its imports

`ifndef BLAKE512_MODEL_SVH
`define BLAKE512_MODEL_SVH

function automatic word_t rotate_right(input word_t x, input int n);
	return (x >> n) | (x << (64 - n));
endfunction

// digest of {data, nonce} with the standard padding and a 640-bit counter
function automatic digest_t blake512_ref(input header_t data, input half_t nonce);
	logic [639:0] hdr;
	word_t bit_cnt;
	word_t m [16];
	word_t v [16];
	digest_t dig;
	int row;
	int j;
	int ia;
	int ib;
	int ic;
	int id;

	hdr = {data, nonce};
	bit_cnt = 64'd640;
	for (int i = 0; i < 10; i++) begin
		m[i] = hdr[639-64*i -: 64];
	end
	// pad bit, final-block marker and the 128-bit length
	m[10] = 64'h8000000000000000;
	m[11] = '0;
	m[12] = '0;
	m[13] = 64'h0000000000000001;
	m[14] = '0;
	m[15] = bit_cnt;

	for (int i = 0; i < 8; i++) begin
		v[i] = BLAKE_IV[i];
		v[i+8] = BLAKE_C[i];
	end
	v[12] = v[12] ^ bit_cnt;
	v[13] = v[13] ^ bit_cnt;

	for (int r = 0; r < NUM_ROUNDS; r++) begin
		row = r % 10;
		for (int k = 0; k < 8; k++) begin
			// first four are columns, last four diagonals
			if (k < 4) begin
				ia = k;
				ib = k + 4;
				ic = k + 8;
				id = k + 12;
			end else begin
				j = k - 4;
				ia = j;
				ib = 4 + (j + 1) % 4;
				ic = 8 + (j + 2) % 4;
				id = 12 + (j + 3) % 4;
			end
			v[ia] = v[ia] + v[ib] + (m[SIGMA[row][2*k]] ^ BLAKE_C[SIGMA[row][2*k+1]]);
			v[id] = rotate_right(v[id] ^ v[ia], 32);
			v[ic] = v[ic] + v[id];
			v[ib] = rotate_right(v[ib] ^ v[ic], 25);
			v[ia] = v[ia] + v[ib] + (m[SIGMA[row][2*k+1]] ^ BLAKE_C[SIGMA[row][2*k]]);
			v[id] = rotate_right(v[id] ^ v[ia], 16);
			v[ic] = v[ic] + v[id];
			v[ib] = rotate_right(v[ib] ^ v[ic], 11);
		end
	end

	for (int i = 0; i < 8; i++) begin
		dig[511-64*i -: 64] = BLAKE_IV[i] ^ v[i] ^ v[i+8];
	end
	return dig;
endfunction

`endif

// ==== tb_blake512.sv ====
// self-checking testbench that drives random headers into the BLAKE-512 pipeline and checks each digest

`timescale 1ns/1ps
`default_nettype none

module tb_blake512
	import blake_types_pkg::*;
	import blake_const_pkg::*;
();

	`include "blake512_model.svh"

	localparam int LATENCY = 65;
	localparam int MAX_WAIT = 200;
	localparam int MIN_CHECKED = 700;

	logic clk;
	logic rst;
	header_t data;
	half_t nonce;
	digest_t hash;
	logic hash_valid;

	integer seed = 46;
	int hash_errors = 0;
	int valid_errors = 0;
	int other_errors = 0;
	int checked = 0;
	int exp_fill = 0;
	header_t fixed_data;
	half_t next_nonce;
	// expected digests of the driven headers in drive order
	digest_t exp_q[$];

	blake512_core u_blake512_core (
		.clk        (clk),
		.rst        (rst),
		.data       (data),
		.nonce      (nonce),
		.hash       (hash),
		.hash_valid (hash_valid)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check_hash(input digest_t got, input digest_t exp, input string msg);
		if (got !== exp) begin
			hash_errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic check_valid(input logic got, input logic exp, input string msg);
		if (got !== exp) begin
			valid_errors++;
			$display("Mismatch at %0t: %s got %b expected %b", $time, msg, got, exp);
		end
	endtask

	task automatic random_header(output header_t h);
		for (int i = 0; i < 19; i++) begin
			h[32*i +: 32] = $random(seed);
		end
	endtask

	// one clock that checks the outputs mid-cycle and then drives the next header
	// mode 0 all zero, 1 random, 2 fixed data with counting nonce
	task automatic step(input int mode, input logic rst_val);
		digest_t exp;
		header_t d;
		half_t n;
		@(negedge clk);
		// rst as sampled by the last rising edge
		if (rst) begin
			exp_fill = 0;
		end else if (exp_fill < LATENCY) begin
			exp_fill++;
		end
		check_valid(hash_valid, exp_fill == LATENCY, "hash_valid level");
		// header driven LATENCY+1 falling edges ago is on hash now
		if (exp_q.size() == LATENCY + 1) begin
			exp = exp_q.pop_front();
			if (hash_valid) begin
				check_hash(hash, exp, "digest");
				checked++;
			end
		end
		case (mode)
			0: begin
				d = '0;
				n = '0;
			end
			1: begin
				random_header(d);
				n = $random(seed);
			end
			default: begin
				d = fixed_data;
				n = next_nonce;
				next_nonce = next_nonce + half_t'(1);
			end
		endcase
		data = d;
		nonce = n;
		rst = rst_val;
		exp_q.push_back(blake512_ref(d, n));
	endtask

	task automatic wait_valid(input int mode, output int count);
		count = 0;
		while (!hash_valid && count < MAX_WAIT) begin
			step(mode, 1'b0);
			count++;
		end
		if (!hash_valid) begin
			other_errors++;
			$display("timeout: hash_valid did not rise within %0d clocks", MAX_WAIT);
		end
	endtask

	// rst high for a number of rising edges, then wait for the pipe to fill
	task automatic reset_and_fill(input int mode, input int cycles);
		int count;
		for (int i = 0; i < cycles - 1; i++) begin
			step(mode, 1'b1);
		end
		step(mode, 1'b0);
		wait_valid(mode, count);
		if (count != LATENCY) begin
			valid_errors++;
			$display("Mismatch at %0t: hash_valid rose %0d clocks after reset, expected %0d",
				$time, count, LATENCY);
		end
	endtask

	initial begin
		rst = 1'b1;
		data = '0;
		nonce = '0;
		fixed_data = '0;
		next_nonce = '0;

		// fill after reset, then a constant all-zero header
		reset_and_fill(0, 4);
		repeat (20) step(0, 1'b0);

		// a new random header every clock
		repeat (400) step(1, 1'b0);

		// same data field with the nonce counting up
		random_header(fixed_data);
		next_nonce = $random(seed);
		repeat (200) step(2, 1'b0);
		repeat (LATENCY + 1) step(1, 1'b0);

		// reset in mid-stream and refill
		reset_and_fill(1, 4);
		repeat (150) step(1, 1'b0);

		if (checked < MIN_CHECKED) begin
			other_errors++;
			$display("only %0d digests were checked, expected at least %0d",
				checked, MIN_CHECKED);
		end
		$display("errors: hash %0d, valid %0d, other %0d, digests checked %0d",
			hash_errors, valid_errors, other_errors, checked);
		if (hash_errors + valid_errors + other_errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire
